// ==== Makefile ====
TOP  = ntm_dot_product_tb
BIN  = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): tb.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f tb.f

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

// ==== hdl/ntm_dot_product.sv ====
// Fixed-point dot product controller, top level
// Captures operand pairs, runs multiplier and adder, counts elements
`timescale 1ns/1ns

module ntm_dot_product (
  // Global
  input  logic              CLK,
  input  logic              RST,

  // Control
  input  logic              START,
  output logic              READY,

  input  logic              DATA_A_IN_ENABLE,
  input  logic              DATA_B_IN_ENABLE,
  output logic              DATA_OUT_ENABLE,

  // Data
  input  ntm_pkg::control_t LENGTH_IN,
  input  ntm_pkg::data_t    DATA_A_IN,
  input  ntm_pkg::data_t    DATA_B_IN,
  output ntm_pkg::data_t    DATA_OUT
);
  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Types and signals
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    STARTER           = 3'd0,
    VECTOR_INITIAL_I  = 3'd1,
    VECTOR_INPUT_I    = 3'd2,
    VECTOR_MULTIPLIER = 3'd3,
    SCALAR_ADDER      = 3'd4,
    VECTOR_UPDATE_I   = 3'd5
  } state_t;

  state_t   state;

  // Element bookkeeping
  control_t length_q;
  control_t index_q;
  logic     last_element;

  // Operand capture
  logic     waiting;
  logic     a_held;
  logic     b_held;
  logic     a_have;
  logic     b_have;
  data_t    a_q;
  data_t    b_q;

  // Running sum
  data_t    sum_q;

  // Multiplier
  logic     mult_start;
  logic     mult_ready;
  data_t    mult_out;

  // Adder
  logic     add_start;
  logic     add_ready;
  data_t    add_out;

  // Operand enables only count in these two states
  assign waiting = (state == VECTOR_INITIAL_I) || (state == VECTOR_INPUT_I);

  // Partner may arrive in the same cycle as the check
  assign a_have = a_held | DATA_A_IN_ENABLE;
  assign b_have = b_held | DATA_B_IN_ENABLE;

  assign last_element = (index_q == length_q - 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
      mult_start      <= 1'b0;
      add_start       <= 1'b0;
      a_held          <= 1'b0;
      b_held          <= 1'b0;
      length_q        <= '0;
      index_q         <= '0;
    end else begin
      // Strobes default low
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      mult_start      <= 1'b0;
      add_start       <= 1'b0;

      if (waiting) begin
        if (DATA_A_IN_ENABLE) begin
          a_held <= 1'b1;
        end
        if (DATA_B_IN_ENABLE) begin
          b_held <= 1'b1;
        end
      end

      case (state)
        STARTER: begin  // Step 0, idle
          if (START) begin
            a_held   <= 1'b0;
            b_held   <= 1'b0;
            length_q <= LENGTH_IN;
            // Empty vector finishes right away
            if (LENGTH_IN == '0) begin
              READY    <= 1'b1;
              DATA_OUT <= '0;
            end else begin
              state <= VECTOR_INITIAL_I;
            end
          end
        end

        VECTOR_INITIAL_I: begin  // Step 1
          index_q <= '0;
          state   <= VECTOR_INPUT_I;
        end

        VECTOR_INPUT_I: begin  // Step 2
          if (a_have && b_have) begin
            a_held     <= 1'b0;
            b_held     <= 1'b0;
            mult_start <= 1'b1;
            state      <= VECTOR_MULTIPLIER;
          end
        end

        VECTOR_MULTIPLIER: begin  // Step 3
          if (mult_ready) begin
            add_start <= 1'b1;
            state     <= SCALAR_ADDER;
          end
        end

        SCALAR_ADDER: begin  // Step 4
          if (add_ready) begin
            state <= VECTOR_UPDATE_I;
          end
        end

        VECTOR_UPDATE_I: begin  // Step 5
          if (last_element) begin
            DATA_OUT <= add_out;
            READY    <= 1'b1;
            state    <= STARTER;
          end else begin
            // Request next pair
            index_q         <= index_q + 1'b1;
            DATA_OUT_ENABLE <= 1'b1;
            state           <= VECTOR_INPUT_I;
          end
        end

        default: begin
          state <= STARTER;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand and sum registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Later strobe for the same element overwrites
    if (waiting && DATA_A_IN_ENABLE) begin
      a_q <= DATA_A_IN;
    end
    if (waiting && DATA_B_IN_ENABLE) begin
      b_q <= DATA_B_IN;
    end

    if (state == VECTOR_INITIAL_I) begin
      sum_q <= '0;
    end else if (state == VECTOR_UPDATE_I) begin
      sum_q <= add_out;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic units
  ////////////////////////////////////////////////////////////////////////////

  // Running sum plus product
  ntm_scalar_fixed_adder scalar_fixed_adder (
    .CLK      (CLK),
    .RST      (RST),
    .START    (add_start),
    .READY    (add_ready),
    .DATA_A_IN(sum_q),
    .DATA_B_IN(mult_out),
    .DATA_OUT (add_out)
  );

  // Element product
  ntm_scalar_fixed_multiplier scalar_fixed_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mult_start),
    .READY    (mult_ready),
    .DATA_A_IN(a_q),
    .DATA_B_IN(b_q),
    .DATA_OUT (mult_out)
  );

endmodule

// ==== hdl/ntm_pkg.sv ====
// Shared widths, fixed-point format, data and length types,
// and saturation limits for the NTM dot product datapath

package ntm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and format
  ////////////////////////////////////////////////////////////////////////////

  // Width of every data word
  localparam int DATA_SIZE = 32;

  // Fraction bits, Q15.16 with DATA_SIZE of 32
  localparam int FRAC_BITS = 16;

  // Vector length and element counter width
  localparam int CONTROL_SIZE = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Operands, products, sums
  typedef logic signed [DATA_SIZE-1:0] data_t;

  // Lengths and element index
  typedef logic [CONTROL_SIZE-1:0] control_t;

  // Saturation limits, two's complement extremes
  localparam data_t DATA_MAX = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam data_t DATA_MIN = {1'b1, {(DATA_SIZE-1){1'b0}}};

endpackage

// ==== hdl/ntm_scalar_fixed_adder.sv ====
// Registered saturating signed fixed-point adder
// START strobe in, READY strobe one cycle later
`timescale 1ns/1ns

module ntm_scalar_fixed_adder (
  // Global
  input  logic           CLK,
  input  logic           RST,

  // Control
  input  logic           START,
  output logic           READY,

  // Data
  input  ntm_pkg::data_t DATA_A_IN,
  input  ntm_pkg::data_t DATA_B_IN,
  output ntm_pkg::data_t DATA_OUT
);
  import ntm_pkg::*;

  // One guard bit above the word
  logic signed [DATA_SIZE:0] sum_wide;
  data_t                     sum_sat;

  // Sum and clamp
  always_comb begin
    sum_wide = DATA_A_IN + DATA_B_IN;
    // Guard bit disagrees with sign bit on overflow
    if (sum_wide[DATA_SIZE] != sum_wide[DATA_SIZE-1]) begin
      sum_sat = sum_wide[DATA_SIZE] ? DATA_MIN : DATA_MAX;
    end else begin
      sum_sat = sum_wide[DATA_SIZE-1:0];
    end
  end

  // Strobe follows START by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  // Result register, held until the next START
  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= sum_sat;
    end
  end

endmodule

// ==== hdl/ntm_scalar_fixed_multiplier.sv ====
// Sequential shift-add signed fixed-point multiplier
// Magnitude product, sign restore, floor rescale and saturation
`timescale 1ns/1ns

module ntm_scalar_fixed_multiplier (
  // Global
  input  logic           CLK,
  input  logic           RST,

  // Control
  input  logic           START,
  output logic           READY,

  // Data
  input  ntm_pkg::data_t DATA_A_IN,
  input  ntm_pkg::data_t DATA_B_IN,
  output ntm_pkg::data_t DATA_OUT
);
  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Control
  logic     busy;
  control_t bit_cnt;
  logic     last_bit;

  // Operand magnitudes, one bit wider so the most negative value fits
  logic signed [DATA_SIZE:0] a_wide;
  logic signed [DATA_SIZE:0] b_wide;

  // Iteration registers
  logic                   result_neg;
  logic [DATA_SIZE-1:0]   mplier_q;
  logic [2*DATA_SIZE-1:0] mcand_q;
  logic [2*DATA_SIZE-1:0] acc_q;
  logic [2*DATA_SIZE-1:0] acc_next;

  // Final stage
  logic signed [2*DATA_SIZE:0] prod_signed;
  logic signed [2*DATA_SIZE:0] prod_scaled;
  data_t                       prod_sat;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign last_bit = (bit_cnt == control_t'(DATA_SIZE - 1));

  always_comb begin
    // Sign-extended magnitudes
    a_wide = DATA_A_IN;
    b_wide = DATA_B_IN;
    if (DATA_A_IN[DATA_SIZE-1]) begin
      a_wide = -a_wide;
    end
    if (DATA_B_IN[DATA_SIZE-1]) begin
      b_wide = -b_wide;
    end

    // Add shifted multiplicand where the current multiplier bit is set
    acc_next = acc_q + (mplier_q[0] ? mcand_q : '0);

    // Restore sign, arithmetic shift rounds toward minus infinity
    prod_signed = result_neg ? -$signed({1'b0, acc_next}) : $signed({1'b0, acc_next});
    prod_scaled = prod_signed >>> FRAC_BITS;

    // Clamp to word range
    if (prod_scaled > DATA_MAX) begin
      prod_sat = DATA_MAX;
    end else if (prod_scaled < DATA_MIN) begin
      prod_sat = DATA_MIN;
    end else begin
      prod_sat = prod_scaled[DATA_SIZE-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  // One load cycle, then DATA_SIZE iterations, READY with the last one
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      READY   <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (!busy) begin
        if (START) begin
          busy    <= 1'b1;
          bit_cnt <= '0;
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        if (last_bit) begin
          busy  <= 1'b0;
          READY <= 1'b1;
        end
      end
    end
  end

  // Operand load and shift-add iteration
  always_ff @(posedge CLK) begin
    if (!busy && START) begin
      result_neg <= DATA_A_IN[DATA_SIZE-1] ^ DATA_B_IN[DATA_SIZE-1];
      // Magnitude of at most 2**(DATA_SIZE-1) fits unsigned
      mplier_q   <= b_wide[DATA_SIZE-1:0];
      mcand_q    <= {{(DATA_SIZE-1){1'b0}}, a_wide};
      acc_q      <= '0;
    end else if (busy) begin
      acc_q    <= acc_next;
      mplier_q <= mplier_q >> 1;
      mcand_q  <= mcand_q << 1;
      // Result held after READY
      if (last_bit) begin
        DATA_OUT <= prod_sat;
      end
    end
  end

endmodule

// ==== tb.f ====
hdl/ntm_pkg.sv
hdl/ntm_scalar_fixed_adder.sv
hdl/ntm_scalar_fixed_multiplier.sv
hdl/ntm_dot_product.sv
verif/ntm_dot_product_tb.sv

// ==== verif/ntm_dot_product_tb.sv ====
// Testbench for the fixed-point dot product unit
// Stimulus, reference model, assertions, test report and watchdog
`timescale 1ns/1ns

module ntm_dot_product_tb;
  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Run constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SEED = 32'hbc5b037e;
  localparam int NUM_RANDOM = 24;
  localparam int MAX_LEN    = 8;
  // Worst-case spread of one pair's delivery, in cycles
  localparam int MAX_GAP    = 16;
  // Directed singles, random vectors, saturation run, split delivery
  localparam int TOTAL_ELEMS = 6 + NUM_RANDOM * MAX_LEN + 18 + 4 * 3;
  localparam int NUM_TESTS   = 2 + 4 + NUM_RANDOM + 3 + 4;
  localparam int CYCLE_LIMIT = TOTAL_ELEMS * (DATA_SIZE + 5 + MAX_GAP) + 20 * NUM_TESTS;

  // Operand delivery order
  localparam int MODE_RANDOM   = 0;
  localparam int MODE_SAME     = 1;
  localparam int MODE_A_FIRST  = 2;
  localparam int MODE_B_FIRST  = 3;
  localparam int MODE_REPEAT_A = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Signals and bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  logic     CLK;
  logic     RST;
  logic     start;
  logic     ready;
  logic     data_a_in_enable;
  logic     data_b_in_enable;
  logic     data_out_enable;
  control_t length_in;
  data_t    data_a_in;
  data_t    data_b_in;
  data_t    data_out;

  // Current vector and its model result
  data_t vec_a [0:31];
  data_t vec_b [0:31];
  data_t expected_sum = '0;
  data_t captured_out = '0;

  // Pulse counters, written only by the monitor
  int ready_count = 0;
  int doe_count   = 0;

  int err_count  = 0;
  int pass_count = 0;
  int fail_count = 0;
  int test_errs  = 0;
  int cycle_count;

  ntm_dot_product dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .READY           (ready),
    .DATA_A_IN_ENABLE(data_a_in_enable),
    .DATA_B_IN_ENABLE(data_b_in_enable),
    .DATA_OUT_ENABLE (data_out_enable),
    .LENGTH_IN       (length_in),
    .DATA_A_IN       (data_a_in),
    .DATA_B_IN       (data_b_in),
    .DATA_OUT        (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Outputs sampled mid-cycle, away from the driving edge
  always @(negedge CLK) begin
    if (ready) begin
      ready_count  = ready_count + 1;
      captured_out = data_out;
    end
    if (data_out_enable) begin
      doe_count = doe_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge CLK) disable iff (RST) !(ready && data_out_enable))
    else begin
      err_count = err_count + 1;
      $display("READY and DATA_OUT_ENABLE were high in the same cycle at %0t", $time);
    end

  assert property (@(posedge CLK) disable iff (RST) ready |-> (data_out == expected_sum))
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: DATA_OUT %h at READY, expected %h", $time, data_out, expected_sum);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic data_t clamp(input longint v);
    if (v > longint'(DATA_MAX)) begin
      return DATA_MAX;
    end
    if (v < longint'(DATA_MIN)) begin
      return DATA_MIN;
    end
    return data_t'(v);
  endfunction

  // Full product, floor shift by the fraction bits, then clamp
  function automatic data_t fixed_product(input data_t a, input data_t b);
    longint full;
    full = longint'(a) * longint'(b);
    return clamp(full >>> FRAC_BITS);
  endfunction

  function automatic data_t fixed_sum(input data_t a, input data_t b);
    return clamp(longint'(a) + longint'(b));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  task automatic pulse_a(input data_t v);
    @(posedge CLK);
    data_a_in        <= v;
    data_a_in_enable <= 1'b1;
    @(posedge CLK);
    data_a_in_enable <= 1'b0;
  endtask

  task automatic pulse_b(input data_t v);
    @(posedge CLK);
    data_b_in        <= v;
    data_b_in_enable <= 1'b1;
    @(posedge CLK);
    data_b_in_enable <= 1'b0;
  endtask

  task automatic pulse_both(input data_t a, input data_t b);
    @(posedge CLK);
    data_a_in        <= a;
    data_b_in        <= b;
    data_a_in_enable <= 1'b1;
    data_b_in_enable <= 1'b1;
    @(posedge CLK);
    data_a_in_enable <= 1'b0;
    data_b_in_enable <= 1'b0;
  endtask

  task automatic start_vector(input int len);
    @(posedge CLK);
    start     <= 1'b1;
    length_in <= control_t'(len);
    @(posedge CLK);
    start     <= 1'b0;
  endtask

  // One pair, random leading gap, order set by mode
  task automatic send_pair(input data_t a, input data_t b, input int mode);
    int how;
    how = (mode == MODE_RANDOM) ? int'($urandom_range(1, 3)) : mode;
    idle_cycles($urandom_range(0, 3));
    case (how)
      MODE_SAME: pulse_both(a, b);
      MODE_A_FIRST: begin
        pulse_a(a);
        idle_cycles($urandom_range(0, 3));
        pulse_b(b);
      end
      MODE_B_FIRST: begin
        pulse_b(b);
        idle_cycles($urandom_range(0, 3));
        pulse_a(a);
      end
      default: begin
        // Stale A first, later A must win
        pulse_a(~a);
        idle_cycles($urandom_range(0, 3));
        pulse_a(a);
        idle_cycles($urandom_range(0, 3));
        pulse_b(b);
      end
    endcase
  endtask

  task automatic report_mismatch(input string what, input data_t got, input data_t exp);
    err_count = err_count + 1;
    $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
  endtask

  // Full vector run against the model, optional START while busy
  task automatic run_vector(input int len, input int mode, input bit restart_mid);
    data_t expected;
    int    doe_base;
    int    ready_base;
    int    want_doe;
    expected = '0;
    for (int i = 0; i < len; i++) begin
      expected = fixed_sum(expected, fixed_product(vec_a[i], vec_b[i]));
    end
    expected_sum = expected;
    want_doe     = (len > 0) ? len - 1 : 0;
    doe_base     = doe_count;
    ready_base   = ready_count;
    start_vector(len);
    for (int i = 0; i < len; i++) begin
      // Each later pair waits for its request
      while (doe_count - doe_base < i) @(posedge CLK);
      send_pair(vec_a[i], vec_b[i], mode);
      if (restart_mid && i == 0) begin
        start_vector(1);
      end
    end
    while (ready_count == ready_base) @(posedge CLK);
    assert (captured_out == expected)
      else report_mismatch("dot product", captured_out, expected);
    assert (doe_count - doe_base == want_doe)
      else begin
        err_count = err_count + 1;
        $display("ERR %0t: DATA_OUT_ENABLE pulsed %0d times instead of %0d",
                 $time, doe_count - doe_base, want_doe);
      end
    idle_cycles(2);
  endtask

  task automatic begin_test;
    test_errs = err_count;
  endtask

  task automatic end_test(input string name);
    if (err_count == test_errs) begin
      pass_count = pass_count + 1;
      $display("test %s: ok", name);
    end else begin
      fail_count = fail_count + 1;
      $display("test %s: FAIL", name);
    end
  endtask

  task automatic run_test(input string name, input int len, input int mode,
                          input bit restart_mid);
    begin_test();
    run_vector(len, mode, restart_mid);
    end_test(name);
  endtask

  // Length one, result also held against a hand value
  task automatic run_single(input string name, input data_t a, input data_t b,
                            input data_t exp);
    begin_test();
    vec_a[0] = a;
    vec_b[0] = b;
    run_vector(1, MODE_SAME, 1'b0);
    assert (captured_out == exp)
      else report_mismatch(name, captured_out, exp);
    end_test(name);
  endtask

  task automatic fill_random(input int len);
    for (int i = 0; i < len; i++) begin
      // About +-128.0, sums of eight may clamp
      vec_a[i] = data_t'($urandom) >>> 8;
      vec_b[i] = data_t'($urandom) >>> 8;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog and main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycle_count = cycle_count + 1;
    end
    $display("timeout, no final result after %0d cycles", cycle_count);
    $display("sim failed");
    $finish;
  end

  initial begin
    int len;
    void'($urandom(SEED));
    RST              = 1'b1;
    start            = 1'b0;
    length_in        = '0;
    data_a_in        = '0;
    data_b_in        = '0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;

    begin_test();
    @(negedge CLK);
    assert (!ready && !data_out_enable)
      else begin
        err_count = err_count + 1;
        $display("ERR %0t: READY or DATA_OUT_ENABLE not low after reset", $time);
      end
    assert (data_out == '0)
      else report_mismatch("DATA_OUT after reset", data_out, '0);
    end_test("reset state");

    // Exact floor rounding on fixed operands
    run_single("1.5 x 2.25", 32'h0001_8000, 32'h0002_4000, 32'h0003_6000);
    run_single("-0.5 x 3.0", 32'hFFFF_8000, 32'h0003_0000, 32'hFFFE_8000);
    run_single("tiny x tiny", 32'h0000_0003, 32'hFFFF_FFFB, 32'hFFFF_FFFF);
    run_single("min x 1.0", DATA_MIN, 32'h0001_0000, DATA_MIN);

    // Empty vector replaces the nonzero result left by the last single
    run_test("zero length", 0, MODE_SAME, 1'b0);

    for (int t = 0; t < NUM_RANDOM; t++) begin
      len = $urandom_range(1, MAX_LEN);
      fill_random(len);
      run_test($sformatf("random %0d length %0d", t, len), len, MODE_RANDOM, 1'b0);
    end

    // Product clamps both ways
    run_single("product high", 32'h7FFF_0000, 32'h0002_0000, DATA_MAX);
    run_single("product low", 32'h7FFF_0000, 32'hFFFE_0000, DATA_MIN);

    // 10000.0 terms, clamp high, fall to clamp low, then climb back
    for (int i = 0; i < 18; i++) begin
      vec_a[i] = 32'h0064_0000;
      vec_b[i] = (i >= 6 && i < 16) ? 32'hFF9C_0000 : 32'h0064_0000;
    end
    run_test("sum clamp and recover", 18, MODE_SAME, 1'b0);

    fill_random(3);
    run_test("B before A", 3, MODE_B_FIRST, 1'b0);
    fill_random(3);
    run_test("A before B", 3, MODE_A_FIRST, 1'b0);
    fill_random(3);
    run_test("repeated A", 3, MODE_REPEAT_A, 1'b0);
    fill_random(3);
    run_test("START while busy", 3, MODE_RANDOM, 1'b1);

    $display("tests: %0d ok, %0d failing, %0d errors", pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
